// ==== source/pacmanPkg.sv ====
`default_nettype none

package pacmanPkg;

  // 640x480 at 60 Hz with a 25 MHz pixel clock
  localparam int hVisible = 640;
  localparam int hFront = 16;
  localparam int hSync = 96;
  localparam int hBack = 48;
  localparam int hTotal = hVisible + hFront + hSync + hBack;

  localparam int vVisible = 480;
  localparam int vFront = 10;
  localparam int vSync = 2;
  localparam int vBack = 33;
  localparam int vTotal = vVisible + vFront + vSync + vBack;

  localparam int posBits = 10;     // wide enough for hTotal and vTotal

  // maze geometry, 16x16 pixel cells on a 32x32 grid
  localparam int cellShift = 4;
  localparam int gridBits = 5;
  localparam int gridMax = 27;     // playable cells are 1..gridMax

  localparam int powerUpX0 = 2;
  localparam int powerUpX1 = 27;
  localparam int powerUpY0 = 4;
  localparam int powerUpY1 = 24;

  localparam int ghostCount = 3;
  localparam int rotBits = 2;
  localparam int aiBits = 4;

  // register bus
  localparam int regAddrBits = 6;
  localparam int regDataBits = 16;
  localparam int regGhostStride = 4; // x, y, rotation, ai state

  localparam logic [regAddrBits-1:0] regGhostBase = 6'd8;
  localparam logic [regAddrBits-1:0] regFrameSync = 6'd32;
  localparam logic [regAddrBits-1:0] regPelletX = 6'd33;
  localparam logic [regAddrBits-1:0] regPelletY = 6'd34;
  localparam logic [regAddrBits-1:0] regPelletClear = 6'd35;
  localparam logic [regAddrBits-1:0] regPelletData = 6'd51; // read only

  localparam logic [aiBits-1:0] aiChase = 4'd0;
  localparam logic [aiBits-1:0] aiScatter = 4'd1;
  localparam logic [aiBits-1:0] aiFrightened = 4'd3;
  localparam logic [aiBits-1:0] aiRespawn = 4'd4;

  typedef logic [2:0] colorT;

  localparam colorT colBlack = 3'd0;  // doubles as transparent
  localparam colorT colBlue = 3'd1;
  localparam colorT colCyan = 3'd3;
  localparam colorT colRed = 3'd4;
  localparam colorT colPink = 3'd5;
  localparam colorT colPellet = 3'd6; // yellow
  localparam colorT colWhite = 3'd7;

  typedef struct packed {
    logic [posBits-1:0] hPos;
    logic [posBits-1:0] vPos;
    logic displayOn;
  } pixelPosT;

  typedef struct packed {
    logic en;
    logic [regAddrBits-1:0] addr;
    logic [regDataBits-1:0] data;
  } regWriteT;

  typedef struct packed {
    logic [gridBits-1:0] x;
    logic [gridBits-1:0] y;
  } cellT;

  typedef struct packed {
    cellT pos;
    logic [rotBits-1:0] rot;
    logic [aiBits-1:0] ai;
  } ghostStateT;

endpackage

`default_nettype wire

// ==== source/videoTiming.sv ====
`timescale 1ns/100ps
`default_nettype none

module videoTiming (
  input  wire logic clk,
  input  wire logic rstN,
  output pacmanPkg::pixelPosT pix,
  output logic frameStart,
  output logic hsync,
  output logic vsync
);
  import pacmanPkg::*;

  localparam int hSyncStart = hVisible + hFront;
  localparam int vSyncStart = vVisible + vFront;

  logic [posBits-1:0] hPos;
  logic [posBits-1:0] vPos;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      hPos <= '0;
      vPos <= '0;
    end else if (hPos == posBits'(hTotal - 1)) begin
      hPos <= '0;
      vPos <= (vPos == posBits'(vTotal - 1)) ? '0 : vPos + 1'b1;
    end else begin
      hPos <= hPos + 1'b1;
    end
  end

  always_comb begin
    pix.hPos = hPos;
    pix.vPos = vPos;
    pix.displayOn = (hPos < hVisible) && (vPos < vVisible);
    hsync = !((hPos >= hSyncStart) && (hPos < hSyncStart + hSync)); // active low
    vsync = !((vPos >= vSyncStart) && (vPos < vSyncStart + vSync));
    // first pixel of vertical blank, game state may change from here
    frameStart = (hPos == '0) && (vPos == posBits'(vVisible));
  end

endmodule

`default_nettype wire

// ==== source/gameRegs.sv ====
`timescale 1ns/100ps
`default_nettype none

module gameRegs (
  input  wire logic clk,
  input  wire logic rstN,
  input  wire logic frameStart,
  input  wire logic pelletHere,
  input  wire logic powerUpHere,
  input  wire pacmanPkg::regWriteT regWrite,
  input  wire logic [pacmanPkg::regAddrBits-1:0] regAddr,
  output logic [pacmanPkg::regDataBits-1:0] regRdata,
  output pacmanPkg::ghostStateT ghost [pacmanPkg::ghostCount],
  output pacmanPkg::cellT pelletCursor,
  output logic pelletClear
);
  import pacmanPkg::*;

  // offsets inside one ghost block
  localparam int fieldX = 0;
  localparam int fieldY = 1;
  localparam int fieldRot = 2;
  localparam int fieldAi = 3;

  logic [regDataBits-1:0] ghostReg [ghostCount][regGhostStride];
  logic [regDataBits-1:0] pelletX;
  logic [regDataBits-1:0] pelletY;
  logic frameSync;
  logic [regDataBits-1:0] rdNext;

  function automatic logic [regAddrBits-1:0] ghostAddr(input int n, input int f);
    return regAddrBits'(regGhostBase + regGhostStride * n + f);
  endfunction

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int n = 0; n < ghostCount; n++) begin
        for (int f = 0; f < regGhostStride; f++) begin
          ghostReg[n][f] <= '0;
        end
      end
      pelletX <= '0;
      pelletY <= '0;
    end else if (regWrite.en) begin
      for (int n = 0; n < ghostCount; n++) begin
        for (int f = 0; f < regGhostStride; f++) begin
          if (regWrite.addr == ghostAddr(n, f)) ghostReg[n][f] <= regWrite.data;
        end
      end
      if (regWrite.addr == regPelletX) pelletX <= regWrite.data;
      if (regWrite.addr == regPelletY) pelletY <= regWrite.data;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      frameSync <= 1'b0;
      pelletClear <= 1'b0;
    end else begin
      if (frameStart) begin
        frameSync <= 1'b1; // the frame event beats a software write
      end else if (regWrite.en && regWrite.addr == regFrameSync) begin
        frameSync <= regWrite.data[0];
      end
      pelletClear <= regWrite.en && (regWrite.addr == regPelletClear) && regWrite.data[0];
    end
  end

  always_comb begin
    rdNext = '0;
    for (int n = 0; n < ghostCount; n++) begin
      for (int f = 0; f < regGhostStride; f++) begin
        if (regAddr == ghostAddr(n, f)) rdNext = ghostReg[n][f];
      end
    end
    case (regAddr)
      regPelletX: rdNext = pelletX;
      regPelletY: rdNext = pelletY;
      regFrameSync: rdNext = regDataBits'(frameSync);
      regPelletData: rdNext = regDataBits'({powerUpHere, pelletHere});
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) regRdata <= '0;
    else regRdata <= rdNext;
  end

  always_comb begin
    for (int n = 0; n < ghostCount; n++) begin
      ghost[n].pos.x = ghostReg[n][fieldX][gridBits-1:0];
      ghost[n].pos.y = ghostReg[n][fieldY][gridBits-1:0];
      ghost[n].rot = ghostReg[n][fieldRot][rotBits-1:0];
      ghost[n].ai = ghostReg[n][fieldAi][aiBits-1:0];
    end
    pelletCursor.x = pelletX[gridBits-1:0];
    pelletCursor.y = pelletY[gridBits-1:0];
  end

endmodule

`default_nettype wire

// ==== source/pelletStore.sv ====
`timescale 1ns/100ps
`default_nettype none

module pelletStore (
  input  wire logic clk,
  input  wire logic rstN,
  input  wire pacmanPkg::pixelPosT pix,
  input  wire pacmanPkg::cellT pelletCursor,
  input  wire logic pelletClear,
  output logic pelletHere,
  output logic powerUpHere,
  output pacmanPkg::colorT color
);
  import pacmanPkg::*;

  localparam int gridCells = 1 << gridBits;
  // dot extent inside a cell, in pixels
  localparam int dotLo = 7;
  localparam int dotHi = 8;
  localparam int powerLo = 5;
  localparam int powerHi = 10;

  logic [gridCells-1:0] grid [gridCells]; // grid[y][x]
  cellT pixCell;
  logic [cellShift-1:0] offX;
  logic [cellShift-1:0] offY;
  logic onGrid;
  logic inDot;

  function automatic logic isPlayable(input int x, input int y);
    return (x >= 1) && (x <= gridMax) && (y >= 1) && (y <= gridMax);
  endfunction

  function automatic logic isPowerUpCell(input cellT c);
    return (c.x == powerUpX0 || c.x == powerUpX1) && (c.y == powerUpY0 || c.y == powerUpY1);
  endfunction

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int y = 0; y < gridCells; y++) begin
        for (int x = 0; x < gridCells; x++) begin
          grid[y][x] <= isPlayable(x, y);
        end
      end
    end else if (pelletClear) begin
      grid[pelletCursor.y][pelletCursor.x] <= 1'b0;
    end
  end

  always_comb begin
    pelletHere = grid[pelletCursor.y][pelletCursor.x];
    powerUpHere = pelletHere && isPowerUpCell(pelletCursor);
  end

  always_comb begin
    pixCell.x = pix.hPos[cellShift +: gridBits];
    pixCell.y = pix.vPos[cellShift +: gridBits];
    offX = pix.hPos[cellShift-1:0];
    offY = pix.vPos[cellShift-1:0];
    // columns past the grid must not wrap back onto it
    onGrid = ((pix.hPos >> (cellShift + gridBits)) == '0) &&
             ((pix.vPos >> (cellShift + gridBits)) == '0);
    if (isPowerUpCell(pixCell)) begin
      inDot = (offX >= powerLo) && (offX <= powerHi) && (offY >= powerLo) && (offY <= powerHi);
    end else begin
      inDot = (offX >= dotLo) && (offX <= dotHi) && (offY >= dotLo) && (offY <= dotHi);
    end
    color = (onGrid && inDot && grid[pixCell.y][pixCell.x]) ? colPellet : colBlack;
  end

endmodule

`default_nettype wire

// ==== source/ghostRenderer.sv ====
`timescale 1ns/100ps
`default_nettype none

module ghostRenderer #(
  parameter pacmanPkg::colorT bodyColor = pacmanPkg::colRed
) (
  input  wire pacmanPkg::pixelPosT pix,
  input  wire pacmanPkg::ghostStateT ghost,
  output pacmanPkg::colorT color
);
  import pacmanPkg::*;

  // sprite layout inside the 16x16 cell
  localparam int bodyTop = 2;
  localparam int bodyBottom = 15;
  localparam int bodyLeft = 1;
  localparam int bodyRight = 14;
  localparam int eyeTop = 4;
  localparam int eyeBottom = 6;
  localparam int leftEyeLo = 3;
  localparam int leftEyeHi = 5;
  localparam int rightEyeLo = 10;
  localparam int rightEyeHi = 12;

  logic inCell;
  logic [cellShift-1:0] offX;
  logic [cellShift-1:0] offY;
  logic [cellShift-1:0] eyeX;
  logic inBody;
  logic inEye;
  colorT bodyShade;

  always_comb begin
    inCell = ((pix.hPos >> cellShift) == posBits'(ghost.pos.x)) &&
             ((pix.vPos >> cellShift) == posBits'(ghost.pos.y));
    offX = pix.hPos[cellShift-1:0];
    offY = pix.vPos[cellShift-1:0];
    eyeX = offX - cellShift'(ghost.rot[0]); // eyes look one column over

    inBody = (offY >= bodyTop) && (offY <= bodyBottom) &&
             (offX >= bodyLeft) && (offX <= bodyRight);
    inEye = (offY >= eyeTop) && (offY <= eyeBottom) &&
            (((eyeX >= leftEyeLo) && (eyeX <= leftEyeHi)) ||
             ((eyeX >= rightEyeLo) && (eyeX <= rightEyeHi)));

    case (ghost.ai)
      aiFrightened: bodyShade = colBlue;
      aiRespawn: bodyShade = colBlack; // only the eyes travel home
      default: bodyShade = bodyColor;
    endcase

    if (!inCell) begin
      color = colBlack;
    end else if (inEye) begin
      color = colWhite;
    end else if (inBody) begin
      color = bodyShade;
    end else begin
      color = colBlack;
    end
  end

endmodule

`default_nettype wire

// ==== source/colorMixer.sv ====
`timescale 1ns/100ps
`default_nettype none

module colorMixer (
  input  wire logic clk,
  input  wire logic rstN,
  input  wire pacmanPkg::pixelPosT pix,
  input  wire pacmanPkg::colorT ghostColor [pacmanPkg::ghostCount],
  input  wire pacmanPkg::colorT pelletColor,
  output pacmanPkg::colorT rgb
);
  import pacmanPkg::*;

  colorT mixed;

  always_comb begin
    mixed = pelletColor;
    // walk from lowest priority up so ghost 0 lands on top
    for (int n = ghostCount - 1; n >= 0; n--) begin
      if (ghostColor[n] != colBlack) mixed = ghostColor[n];
    end
    if (!pix.displayOn) mixed = colBlack;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) rgb <= colBlack;
    else rgb <= mixed;
  end

endmodule

`default_nettype wire

// ==== source/pacmanVideoTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module pacmanVideoTop (
  input  wire logic clk,
  input  wire logic rstN,
  input  wire pacmanPkg::regWriteT regWrite,
  input  wire logic [pacmanPkg::regAddrBits-1:0] regAddr,
  output logic [pacmanPkg::regDataBits-1:0] regRdata,
  output logic hsync,
  output logic vsync,
  output pacmanPkg::colorT rgb
);
  import pacmanPkg::*;

  pixelPosT pix;
  logic frameStart;
  ghostStateT ghost [ghostCount];
  cellT pelletCursor;
  logic pelletClear;
  logic pelletHere;
  logic powerUpHere;
  colorT ghostColor [ghostCount];
  colorT pelletColor;

  videoTiming timing0 (.clk, .rstN, .pix, .frameStart, .hsync, .vsync);

  gameRegs regs0 (
    .clk, .rstN, .frameStart, .pelletHere, .powerUpHere,
    .regWrite, .regAddr, .regRdata,
    .ghost, .pelletCursor, .pelletClear
  );

  pelletStore pellets0 (
    .clk, .rstN, .pix, .pelletCursor, .pelletClear,
    .pelletHere, .powerUpHere, .color(pelletColor)
  );

  ghostRenderer #(.bodyColor(colRed)) ghost0 (
    .pix, .ghost(ghost[0]), .color(ghostColor[0])
  );

  ghostRenderer #(.bodyColor(colPink)) ghost1 (
    .pix, .ghost(ghost[1]), .color(ghostColor[1])
  );

  ghostRenderer #(.bodyColor(colCyan)) ghost2 (
    .pix, .ghost(ghost[2]), .color(ghostColor[2])
  );

  colorMixer mixer0 (.clk, .rstN, .pix, .ghostColor, .pelletColor, .rgb);

endmodule

`default_nettype wire

// ==== tests/pacmanTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module pacmanTb;
  import pacmanPkg::*;

  typedef enum logic [2:0] {opWrite, opRead, opPixel, opFrame, opScan} opT;

  typedef struct packed {
    opT op;
    logic [5:0] addr;
    logic [9:0] x;
    logic [9:0] y;
    logic [15:0] data;
    logic [15:0] expVal;
  } entryT;

  logic clk = 1'b0;
  logic rstN;
  regWriteT regWrite;
  logic [5:0] regAddr;
  logic [15:0] regRdata;
  logic hsync;
  logic vsync;
  colorT rgb;

  entryT steps [$];
  bit pelletModel [32][32]; // [y][x]
  logic [31:0] rngState = 32'd66335;
  int errorCount = 0;
  int mh; // modelled pixel position
  int mv;

  pacmanVideoTop dut0 (.clk, .rstN, .regWrite, .regAddr, .regRdata, .hsync, .vsync, .rgb);

  always #10 clk = ~clk;

  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mh <= 0;
      mv <= 0;
    end else if (mh == hTotal - 1) begin
      mh <= 0;
      mv <= (mv == vTotal - 1) ? 0 : mv + 1;
    end else begin
      mh <= mh + 1;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [5:0] ghostRegAddr(input int n, input int f);
    return 6'(regGhostBase + regGhostStride * n + f);
  endfunction

  // status bits as read at regPelletData
  function automatic logic [15:0] pelletStatus(input int x, input int y);
    logic powerCell;
    powerCell = (x == powerUpX0 || x == powerUpX1) && (y == powerUpY0 || y == powerUpY1);
    return {14'd0, pelletModel[y][x] && powerCell, pelletModel[y][x]};
  endfunction

  task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] expVal);
    assert (got === expVal) else begin
      errorCount++;
      $display("CHECK FAILED %s expected %h got %h at %0t", name, expVal, got, $time);
    end
  endtask

  task automatic addEntry(input opT op, input logic [5:0] addr, input int x, input int y,
                          input logic [15:0] data, input logic [15:0] expVal);
    entryT e;
    e.op = op;
    e.addr = addr;
    e.x = 10'(x);
    e.y = 10'(y);
    e.data = data;
    e.expVal = expVal;
    steps.push_back(e);
  endtask

  task automatic addWrite(input logic [5:0] addr, input logic [15:0] data);
    addEntry(opWrite, addr, 0, 0, data, 16'd0);
  endtask

  task automatic addRead(input logic [5:0] addr, input logic [15:0] expVal);
    addEntry(opRead, addr, 0, 0, 16'd0, expVal);
  endtask

  task automatic addPixel(input int x, input int y, input colorT expVal);
    addEntry(opPixel, 6'd0, x, y, 16'd0, 16'(expVal));
  endtask

  task automatic addCursorRead(input int x, input int y);
    addWrite(regPelletX, 16'(x));
    addWrite(regPelletY, 16'(y));
    addRead(regPelletData, pelletStatus(x, y));
  endtask

  task automatic buildSteps();
    logic [15:0] ghostData [ghostCount][4];
    logic [5:0] unusedAddr [6] = '{6'd0, 6'd5, 6'd20, 6'd31, 6'd40, 6'd63};
    int gx;
    int gy;
    for (int y = 0; y < 32; y++) begin
      for (int x = 0; x < 32; x++) begin
        pelletModel[y][x] = (x >= 1) && (x <= gridMax) && (y >= 1) && (y <= gridMax);
      end
    end
    addRead(regFrameSync, 16'd0); // still in the first visible area
    for (int n = 0; n < ghostCount; n++) begin
      for (int f = 0; f < 4; f++) begin
        rngState = xorshift32(rngState);
        ghostData[n][f] = rngState[15:0];
        addWrite(ghostRegAddr(n, f), ghostData[n][f]);
      end
    end
    for (int n = 0; n < ghostCount; n++) begin
      for (int f = 0; f < 4; f++) addRead(ghostRegAddr(n, f), ghostData[n][f]);
    end
    foreach (unusedAddr[i]) begin
      addRead(unusedAddr[i], 16'd0);
    end
    addWrite(ghostRegAddr(2, 1), 16'd30); // ghost 2 drawn inside the vertical blank
    addEntry(opScan, 6'd0, 0, 0, 16'd0, 16'd0);
    addEntry(opFrame, 6'd0, 0, 0, 16'd0, 16'd0);
    addRead(regFrameSync, 16'd1);
    addWrite(regFrameSync, 16'd0);
    addRead(regFrameSync, 16'd0);
    addEntry(opFrame, 6'd0, 0, 0, 16'd0, 16'd0);
    addRead(regFrameSync, 16'd1);

    // park every ghost on cell (0,0), which holds no pellet
    for (int n = 0; n < ghostCount; n++) begin
      addWrite(ghostRegAddr(n, 0), 16'd0);
      addWrite(ghostRegAddr(n, 1), 16'd0);
      addWrite(ghostRegAddr(n, 3), 16'(aiChase));
    end

    addCursorRead(5, 5);
    addCursorRead(2, 4);
    addCursorRead(0, 0);
    addPixel(87, 87, colPellet);
    addWrite(regPelletX, 16'd5);
    addWrite(regPelletY, 16'd5);
    addWrite(regPelletClear, 16'd1);
    pelletModel[5][5] = 1'b0;
    addRead(regPelletData, pelletStatus(5, 5));
    addCursorRead(4, 5);
    addCursorRead(6, 5);
    addCursorRead(5, 4);
    addCursorRead(5, 6);
    addPixel(87, 87, colBlack);

    // ghost 0 somewhere clear of cell (5,5), others parked at (0,0)
    rngState = xorshift32(rngState);
    gx = 6 + int'(rngState % 22);
    rngState = xorshift32(rngState);
    gy = 6 + int'(rngState % 22);
    addWrite(ghostRegAddr(0, 0), 16'(gx));
    addWrite(ghostRegAddr(0, 1), 16'(gy));
    addWrite(ghostRegAddr(0, 2), 16'd0);
    addWrite(ghostRegAddr(0, 3), 16'(aiChase));
    addPixel(gx * 16 + 8, gy * 16 + 8, colRed); // body row 8, below the eyes
    addWrite(ghostRegAddr(0, 3), 16'(aiFrightened));
    addPixel(gx * 16 + 8, gy * 16 + 8, colBlue);
    addWrite(ghostRegAddr(0, 3), 16'(aiRespawn));
    addPixel(gx * 16 + 8, gy * 16 + 8, colPellet);
    addWrite(ghostRegAddr(1, 0), 16'(gx));
    addWrite(ghostRegAddr(1, 1), 16'(gy));
    addPixel(gx * 16 + 8, gy * 16 + 8, colPink);
    addWrite(ghostRegAddr(0, 3), 16'(aiChase));
    addPixel(gx * 16 + 8, gy * 16 + 8, colRed);
  endtask

  task automatic writeReg(input logic [5:0] addr, input logic [15:0] data);
    @(posedge clk);
    regWrite <= '{en: 1'b1, addr: addr, data: data};
    @(posedge clk);
    regWrite.en <= 1'b0;
  endtask

  task automatic readCheck(input logic [5:0] addr, input logic [15:0] expVal);
    @(posedge clk);
    regAddr <= addr;
    @(posedge clk); // read data registered here
    @(negedge clk);
    checkValue("regRdata", regRdata, expVal);
  endtask

  task automatic pixelCheck(input int x, input int y, input colorT expVal);
    @(negedge clk);
    while (mh != x || mv != y) @(negedge clk);
    @(negedge clk);
    checkValue("rgb", 16'(rgb), 16'(expVal));
  endtask

  task automatic waitFrameStart();
    @(negedge clk);
    while (mh != 0 || mv != vVisible) @(negedge clk);
  endtask

  // one whole frame of sync windows and blanking
  task automatic scanFrame();
    logic lastOn;
    logic hExp;
    logic vExp;
    @(negedge clk);
    lastOn = (mh < hVisible) && (mv < vVisible);
    repeat (hTotal * vTotal) begin
      @(negedge clk);
      hExp = !(mh >= hVisible + hFront && mh < hVisible + hFront + hSync);
      vExp = !(mv >= vVisible + vFront && mv < vVisible + vFront + vSync);
      checkValue("hsync", 16'(hsync), 16'(hExp));
      checkValue("vsync", 16'(vsync), 16'(vExp));
      if (!lastOn) checkValue("rgb", 16'(rgb), 16'(colBlack));
      lastOn = (mh < hVisible) && (mv < vVisible);
    end
  endtask

  task automatic runStep(input entryT s);
    case (s.op)
      opWrite: writeReg(s.addr, s.data);
      opRead: readCheck(s.addr, s.expVal);
      opPixel: pixelCheck(int'(s.x), int'(s.y), s.expVal[2:0]);
      opFrame: waitFrameStart();
      opScan: scanFrame();
      default: ;
    endcase
  endtask

  initial begin
    rstN = 1'b0;
    regWrite = '0;
    regAddr = '0;
    buildSteps();
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    foreach (steps[i]) runStep(steps[i]);
    repeat (4) @(posedge clk);
    $display("steps run: %0d, errors: %0d", steps.size(), errorCount);
    if (errorCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    int limit;
    #1;
    limit = (steps.size() + 3) * hTotal * vTotal; // each step waits at most a frame
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, the test sequence did not complete", limit);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/pacmanPkg.sv
source/videoTiming.sv
source/gameRegs.sv
source/pelletStore.sv
source/ghostRenderer.sv
source/colorMixer.sv
source/pacmanVideoTop.sv
tests/pacmanTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = pacmanTb
FILELIST = list.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
